// ==== dma_cluster.f ====
rtl/dma_pkg.sv
rtl/dma_word_if.sv
rtl/dma_ctrl_regs.sv
rtl/dma_burst_engine.sv
rtl/dma_addr_router.sv
rtl/dma_mem_port.sv
rtl/dma_cluster_top.sv
tests/dma_mem_model.sv
tests/dma_cluster_tb.sv

// ==== rtl/dma_addr_router.sv ====
// address router: splits words between tcdm and soc ports, keeps read data in order
module dma_addr_router (
  input  logic                       clk_i,
  input  logic                       reset_i,
  dma_word_if.router                 word,
  output logic                       tcdm_valid_o,
  output logic                       tcdm_we_o,
  output logic [dma_pkg::addr_w-1:0] tcdm_addr_o,
  output logic [dma_pkg::data_w-1:0] tcdm_wdata_o,
  output logic                       soc_valid_o,
  output logic                       soc_we_o,
  output logic [dma_pkg::addr_w-1:0] soc_addr_o,
  output logic [dma_pkg::data_w-1:0] soc_wdata_o,
  input  logic                       tcdm_done_i,
  input  logic                       tcdm_rvalid_i,
  input  logic [dma_pkg::data_w-1:0] tcdm_rdata_i,
  input  logic                       soc_done_i,
  input  logic                       soc_rvalid_i,
  input  logic [dma_pkg::data_w-1:0] soc_rdata_i
);
  import dma_pkg::*;

  // side of each outstanding read, 1 for tcdm
  logic order_q [router_credits];
  logic [rq_ptr_w-1:0] head_q;
  logic [rq_ptr_w-1:0] tail_q;
  logic [credit_w-1:0] count_q;
  logic to_tcdm;
  logic push_rd;
  logic head_tcdm;

  assign to_tcdm = (word.req_addr >= tcdm_base) && (word.req_addr < tcdm_end);
  assign push_rd = word.req_valid && !word.req_we;
  assign head_tcdm = order_q[head_q];

  assign tcdm_valid_o = word.req_valid && to_tcdm;
  assign tcdm_we_o = word.req_we;
  assign tcdm_addr_o = word.req_addr;
  assign tcdm_wdata_o = word.req_wdata;
  assign soc_valid_o = word.req_valid && !to_tcdm;
  assign soc_we_o = word.req_we;
  assign soc_addr_o = word.req_addr;
  assign soc_wdata_o = word.req_wdata;

  assign word.rsp_valid = (count_q != '0) && (head_tcdm ? tcdm_rvalid_i : soc_rvalid_i);
  assign word.rsp_rdata = head_tcdm ? tcdm_rdata_i : soc_rdata_i;
  assign word.credit_return = 2'(tcdm_done_i) + 2'(soc_done_i) + 2'(word.rsp_valid);

  always_ff @(posedge clk_i) begin
    if (push_rd) begin
      order_q[tail_q] <= to_tcdm;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      head_q <= '0;
      tail_q <= '0;
      count_q <= '0;
    end else begin
      if (push_rd) begin
        tail_q <= tail_q + 1'b1;
      end
      if (word.rsp_valid) begin
        head_q <= head_q + 1'b1;
      end
      count_q <= count_q + credit_w'(push_rd) - credit_w'(word.rsp_valid);
    end
  end

  // read data only from the side of the oldest outstanding read
  tcdm_rsp_in_order: assert property (@(posedge clk_i) disable iff (reset_i)
    tcdm_rvalid_i |-> (count_q != '0) && head_tcdm);
  soc_rsp_in_order: assert property (@(posedge clk_i) disable iff (reset_i)
    soc_rvalid_i |-> (count_q != '0) && !head_tcdm);

endmodule

// ==== rtl/dma_burst_engine.sv ====
// copy engine: reads source words into a small buffer and writes them to the destination
module dma_burst_engine (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               start_i,
  input  dma_pkg::xfer_cmd_t cmd_i,
  output logic               done_o,
  dma_word_if.engine         word
);
  import dma_pkg::*;

  logic active_q;
  logic [addr_w-1:0] rd_addr_q;
  logic [addr_w-1:0] wr_addr_q;
  logic [len_w-1:0] rd_left_q;
  logic [len_w-1:0] wr_left_q;
  logic [credit_w-1:0] credits_q;
  // slots taken by reads in flight or by buffered data
  logic [buf_cnt_w-1:0] used_q;
  logic [buf_cnt_w-1:0] fill_q;
  logic [buf_ptr_w-1:0] push_ptr_q;
  logic [buf_ptr_w-1:0] pop_ptr_q;
  logic [data_w-1:0] fifo_q [buf_depth];
  logic has_credit;
  logic issue_wr;
  logic issue_rd;

  assign has_credit = credits_q != '0;

  // writes drain the buffer first, reads only fill reserved space
  assign issue_wr = active_q && (fill_q != '0) && has_credit;
  assign issue_rd = active_q && !issue_wr && (rd_left_q != '0) && has_credit
                    && (used_q < buf_cnt_w'(buf_depth));

  // all writes issued and every credit back
  assign done_o = active_q && (wr_left_q == '0) && (credits_q == credit_w'(router_credits));

  assign word.req_valid = issue_wr || issue_rd;
  assign word.req_we = issue_wr;
  assign word.req_addr = issue_wr ? wr_addr_q : rd_addr_q;
  assign word.req_wdata = fifo_q[pop_ptr_q];

  always_ff @(posedge clk_i) begin
    if (word.rsp_valid) begin
      fifo_q[push_ptr_q] <= word.rsp_rdata;
    end
    if (start_i) begin
      rd_addr_q <= cmd_i.src;
      wr_addr_q <= cmd_i.dst;
    end else begin
      if (issue_rd) begin
        rd_addr_q <= rd_addr_q + addr_w'(4);
      end
      if (issue_wr) begin
        wr_addr_q <= wr_addr_q + addr_w'(4);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      active_q <= 1'b0;
      rd_left_q <= '0;
      wr_left_q <= '0;
      credits_q <= credit_w'(router_credits);
      used_q <= '0;
      fill_q <= '0;
      push_ptr_q <= '0;
      pop_ptr_q <= '0;
    end else begin
      credits_q <= credits_q - credit_w'(word.req_valid) + credit_w'(word.credit_return);
      used_q <= used_q + buf_cnt_w'(issue_rd) - buf_cnt_w'(issue_wr);
      fill_q <= fill_q + buf_cnt_w'(word.rsp_valid) - buf_cnt_w'(issue_wr);
      if (word.rsp_valid) begin
        push_ptr_q <= push_ptr_q + 1'b1;
      end
      if (issue_wr) begin
        pop_ptr_q <= pop_ptr_q + 1'b1;
      end
      if (start_i) begin
        active_q <= 1'b1;
        rd_left_q <= cmd_i.len;
        wr_left_q <= cmd_i.len;
      end else begin
        if (done_o) begin
          active_q <= 1'b0;
        end
        if (issue_rd) begin
          rd_left_q <= rd_left_q - 1'b1;
        end
        if (issue_wr) begin
          wr_left_q <= wr_left_q - 1'b1;
        end
      end
    end
  end

  // router never returns more credits than were spent
  credit_bound: assert property (@(posedge clk_i) disable iff (reset_i)
    credits_q <= credit_w'(router_credits));

  // read data always lands in a reserved slot
  fifo_no_overflow: assert property (@(posedge clk_i) disable iff (reset_i)
    word.rsp_valid |-> fill_q < buf_cnt_w'(buf_depth));

endmodule

// ==== rtl/dma_cluster_top.sv ====
// cluster dma top: control registers, copy engine, address router and two memory ports
module dma_cluster_top (
  input  logic                           clk_i,
  input  logic                           reset_i,
  input  logic                           cfg_req_i,
  input  logic                           cfg_we_i,
  input  logic [dma_pkg::addr_w-1:0]     cfg_addr_i,
  input  logic [dma_pkg::data_w-1:0]     cfg_wdata_i,
  input  logic [dma_pkg::core_id_w-1:0]  cfg_core_i,
  output logic                           cfg_gnt_o,
  output logic                           cfg_rvalid_o,
  output logic [dma_pkg::data_w-1:0]     cfg_rdata_o,
  output logic                           tcdm_req_o,
  output logic                           tcdm_we_o,
  output logic [dma_pkg::addr_w-1:0]     tcdm_addr_o,
  output logic [dma_pkg::data_w-1:0]     tcdm_wdata_o,
  input  logic                           tcdm_gnt_i,
  input  logic                           tcdm_rvalid_i,
  input  logic [dma_pkg::data_w-1:0]     tcdm_rdata_i,
  output logic                           soc_req_o,
  output logic                           soc_we_o,
  output logic [dma_pkg::addr_w-1:0]     soc_addr_o,
  output logic [dma_pkg::data_w-1:0]     soc_wdata_o,
  input  logic                           soc_gnt_i,
  input  logic                           soc_rvalid_i,
  input  logic [dma_pkg::data_w-1:0]     soc_rdata_i,
  output logic [dma_pkg::num_cores-1:0]  busy_o,
  output logic [dma_pkg::num_cores-1:0]  term_event_o,
  output logic [dma_pkg::num_cores-1:0]  term_irq_o
);
  import dma_pkg::*;

  dma_word_if word_if ();

  xfer_cmd_t cmd;
  logic start;
  logic done;
  // router to port requests
  logic tcdm_valid, tcdm_we, soc_valid, soc_we;
  logic [addr_w-1:0] tcdm_addr, soc_addr;
  logic [data_w-1:0] tcdm_wdata, soc_wdata;
  // port to router completions
  logic tcdm_done, tcdm_rvalid, soc_done, soc_rvalid;
  logic [data_w-1:0] tcdm_rdata, soc_rdata;

  dma_ctrl_regs ctrl_inst (
    .clk_i, .reset_i, .cfg_req_i, .cfg_we_i, .cfg_addr_i, .cfg_wdata_i, .cfg_core_i,
    .done_i(done), .cfg_gnt_o, .cfg_rvalid_o, .cfg_rdata_o, .start_o(start), .cmd_o(cmd),
    .busy_o, .term_event_o, .term_irq_o
  );

  dma_burst_engine engine_inst (
    .clk_i, .reset_i, .start_i(start), .cmd_i(cmd), .done_o(done), .word(word_if.engine)
  );

  dma_addr_router router_inst (
    .clk_i, .reset_i, .word(word_if.router),
    .tcdm_valid_o(tcdm_valid), .tcdm_we_o(tcdm_we), .tcdm_addr_o(tcdm_addr),
    .tcdm_wdata_o(tcdm_wdata), .soc_valid_o(soc_valid), .soc_we_o(soc_we),
    .soc_addr_o(soc_addr), .soc_wdata_o(soc_wdata),
    .tcdm_done_i(tcdm_done), .tcdm_rvalid_i(tcdm_rvalid), .tcdm_rdata_i(tcdm_rdata),
    .soc_done_i(soc_done), .soc_rvalid_i(soc_rvalid), .soc_rdata_i(soc_rdata)
  );

  dma_mem_port tcdm_port_inst (
    .clk_i, .reset_i, .valid_i(tcdm_valid), .we_i(tcdm_we), .addr_i(tcdm_addr),
    .wdata_i(tcdm_wdata), .mem_gnt_i(tcdm_gnt_i), .mem_rvalid_i(tcdm_rvalid_i),
    .mem_rdata_i(tcdm_rdata_i), .accepted_o(tcdm_done), .rvalid_o(tcdm_rvalid),
    .rdata_o(tcdm_rdata), .mem_req_o(tcdm_req_o), .mem_we_o(tcdm_we_o),
    .mem_addr_o(tcdm_addr_o), .mem_wdata_o(tcdm_wdata_o)
  );

  dma_mem_port soc_port_inst (
    .clk_i, .reset_i, .valid_i(soc_valid), .we_i(soc_we), .addr_i(soc_addr),
    .wdata_i(soc_wdata), .mem_gnt_i(soc_gnt_i), .mem_rvalid_i(soc_rvalid_i),
    .mem_rdata_i(soc_rdata_i), .accepted_o(soc_done), .rvalid_o(soc_rvalid),
    .rdata_o(soc_rdata), .mem_req_o(soc_req_o), .mem_we_o(soc_we_o),
    .mem_addr_o(soc_addr_o), .mem_wdata_o(soc_wdata_o)
  );

endmodule

// ==== rtl/dma_ctrl_regs.sv ====
// dma control registers for the core config port, transfer launch and completion events
module dma_ctrl_regs (
  input  logic                              clk_i,
  input  logic                              reset_i,
  input  logic                              cfg_req_i,
  input  logic                              cfg_we_i,
  input  logic [dma_pkg::addr_w-1:0]        cfg_addr_i,
  input  logic [dma_pkg::data_w-1:0]        cfg_wdata_i,
  input  logic [dma_pkg::core_id_w-1:0]     cfg_core_i,
  input  logic                              done_i,
  output logic                              cfg_gnt_o,
  output logic                              cfg_rvalid_o,
  output logic [dma_pkg::data_w-1:0]        cfg_rdata_o,
  output logic                              start_o,
  output dma_pkg::xfer_cmd_t                cmd_o,
  output logic [dma_pkg::num_cores-1:0]     busy_o,
  output logic [dma_pkg::num_cores-1:0]     term_event_o,
  output logic [dma_pkg::num_cores-1:0]     term_irq_o
);
  import dma_pkg::*;

  logic [addr_w-1:0] src_q;
  logic [addr_w-1:0] dst_q;
  logic [len_w-1:0] len_q;
  logic irq_en_q;
  logic [core_id_w-1:0] core_q;
  logic [15:0] done_cnt_q;
  logic busy_q;
  logic start_q;
  logic [3:0] reg_sel;
  logic is_launch;
  logic launch;
  logic [num_cores-1:0] core_mask;
  cfg_word_u wr_word;
  cfg_word_u rd_word;

  assign reg_sel = cfg_addr_i[3:0];
  assign wr_word = cfg_wdata_i;
  assign is_launch = cfg_we_i && (reg_sel == reg_len);

  // a new launch waits until the running copy has ended
  assign cfg_gnt_o = cfg_req_i && !(is_launch && busy_q);
  assign launch = cfg_gnt_o && is_launch;

  always_comb begin
    core_mask = '0;
    core_mask[core_q] = 1'b1;
  end

  always_comb begin
    rd_word.addr = '0;
    case (reg_sel)
      reg_src: rd_word.addr = src_q;
      reg_dst: rd_word.addr = dst_q;
      reg_len: begin
        rd_word.len_cmd.irq_en = irq_en_q;
        rd_word.len_cmd.len = len_q;
      end
      reg_status: rd_word.addr = {done_cnt_q, 15'b0, busy_q};
      default: rd_word.addr = '0;
    endcase
  end

  // register contents and read data
  always_ff @(posedge clk_i) begin
    if (cfg_gnt_o && cfg_we_i) begin
      case (reg_sel)
        reg_src: src_q <= wr_word.addr;
        reg_dst: dst_q <= wr_word.addr;
        reg_len: len_q <= wr_word.len_cmd.len;
        default: ;
      endcase
    end
    if (cfg_gnt_o && !cfg_we_i) begin
      cfg_rdata_o <= rd_word.addr;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q <= 1'b0;
      start_q <= 1'b0;
      irq_en_q <= 1'b0;
      core_q <= '0;
      done_cnt_q <= '0;
      cfg_rvalid_o <= 1'b0;
      term_event_o <= '0;
      term_irq_o <= '0;
    end else begin
      start_q <= launch;
      cfg_rvalid_o <= cfg_gnt_o && !cfg_we_i;
      // completion goes back to the core that launched
      term_event_o <= done_i ? core_mask : '0;
      term_irq_o <= (done_i && irq_en_q) ? core_mask : '0;
      if (launch) begin
        busy_q <= 1'b1;
        irq_en_q <= wr_word.len_cmd.irq_en;
        core_q <= cfg_core_i;
      end else if (done_i) begin
        busy_q <= 1'b0;
      end
      if (done_i) begin
        done_cnt_q <= done_cnt_q + 16'd1;
      end
    end
  end

  assign start_o = start_q;
  assign busy_o = busy_q ? core_mask : '0;
  assign cmd_o = '{src: src_q, dst: dst_q, len: len_q, core: core_q};

  // the engine only finishes a copy that was launched
  done_while_busy: assert property (@(posedge clk_i) disable iff (reset_i)
    done_i |-> busy_q && !start_q);

endmodule

// ==== rtl/dma_mem_port.sv ====
// memory port: queues routed words and holds each request on the bus until granted
module dma_mem_port (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       valid_i,
  input  logic                       we_i,
  input  logic [dma_pkg::addr_w-1:0] addr_i,
  input  logic [dma_pkg::data_w-1:0] wdata_i,
  input  logic                       mem_gnt_i,
  input  logic                       mem_rvalid_i,
  input  logic [dma_pkg::data_w-1:0] mem_rdata_i,
  output logic                       accepted_o,
  output logic                       rvalid_o,
  output logic [dma_pkg::data_w-1:0] rdata_o,
  output logic                       mem_req_o,
  output logic                       mem_we_o,
  output logic [dma_pkg::addr_w-1:0] mem_addr_o,
  output logic [dma_pkg::data_w-1:0] mem_wdata_o
);
  import dma_pkg::*;

  // one slot per credit, so a stalled memory never fills it
  logic we_q [router_credits];
  logic [addr_w-1:0] addr_q [router_credits];
  logic [data_w-1:0] wdata_q [router_credits];
  logic [rq_ptr_w-1:0] head_q;
  logic [rq_ptr_w-1:0] tail_q;
  logic [credit_w-1:0] count_q;
  logic granted;

  assign mem_req_o = count_q != '0;
  assign mem_we_o = we_q[head_q];
  assign mem_addr_o = addr_q[head_q];
  assign mem_wdata_o = wdata_q[head_q];
  assign granted = mem_req_o && mem_gnt_i;

  // writes finish on grant, reads when their data comes back
  assign accepted_o = granted && mem_we_o;
  assign rvalid_o = mem_rvalid_i;
  assign rdata_o = mem_rdata_i;

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      we_q[tail_q] <= we_i;
      addr_q[tail_q] <= addr_i;
      wdata_q[tail_q] <= wdata_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      head_q <= '0;
      tail_q <= '0;
      count_q <= '0;
    end else begin
      if (valid_i) begin
        tail_q <= tail_q + 1'b1;
      end
      if (granted) begin
        head_q <= head_q + 1'b1;
      end
      count_q <= count_q + credit_w'(valid_i) - credit_w'(granted);
    end
  end

  // a stalled request keeps its values
  req_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_req_o && !mem_gnt_i |=> mem_req_o && $stable(mem_we_o)
      && $stable(mem_addr_o) && $stable(mem_wdata_o));

  // engine credits keep the queue from filling up
  queue_no_overflow: assert property (@(posedge clk_i) disable iff (reset_i)
    valid_i |-> count_q < credit_w'(router_credits));

endmodule

// ==== rtl/dma_pkg.sv ====
// dma package: widths, register map and command types shared by the cluster dma
package dma_pkg;

  localparam int num_cores = 2;
  localparam int addr_w = 32;
  localparam int data_w = 32;
  localparam int len_w = 16;
  localparam int core_id_w = 1;

  // requests that router and memory ports can hold in flight
  localparam int router_credits = 4;
  localparam int buf_depth = 4;

  localparam int credit_w = $clog2(router_credits + 1);
  localparam int rq_ptr_w = $clog2(router_credits);
  localparam int buf_ptr_w = $clog2(buf_depth);
  localparam int buf_cnt_w = $clog2(buf_depth + 1);

  // tcdm window, end is exclusive
  localparam logic [addr_w-1:0] tcdm_base = 32'h1000_0000;
  localparam logic [addr_w-1:0] tcdm_end = 32'h1010_0000;

  localparam logic [3:0] reg_src = 4'h0;
  localparam logic [3:0] reg_dst = 4'h4;
  localparam logic [3:0] reg_len = 4'h8;
  localparam logic [3:0] reg_status = 4'hc;

  typedef struct packed {
    logic irq_en;
    logic [14:0] unused;
    logic [len_w-1:0] len;
  } len_cmd_t;

  // one config word, an address for src/dst or a length command
  typedef union packed {
    logic [addr_w-1:0] addr;
    len_cmd_t len_cmd;
  } cfg_word_u;

  typedef struct packed {
    logic [addr_w-1:0] src;
    logic [addr_w-1:0] dst;
    logic [len_w-1:0] len;
    logic [core_id_w-1:0] core;
  } xfer_cmd_t;

endpackage

// ==== rtl/dma_word_if.sv ====
// word channel between copy engine and address router, with credit-based flow control
interface dma_word_if;
  import dma_pkg::*;

  // requests, one per cycle at most
  logic req_valid;
  logic req_we;
  logic [addr_w-1:0] req_addr;
  logic [data_w-1:0] req_wdata;

  // number of requests finished this cycle, up to three
  logic [1:0] credit_return;

  // read data in issue order
  logic rsp_valid;
  logic [data_w-1:0] rsp_rdata;

  modport engine (
    output req_valid, req_we, req_addr, req_wdata,
    input credit_return, rsp_valid, rsp_rdata
  );

  modport router (
    input req_valid, req_we, req_addr, req_wdata,
    output credit_return, rsp_valid, rsp_rdata
  );

endinterface

// ==== tests/dma_cluster_tb.sv ====
// cluster dma testbench that programs copies through the config port and checks the traffic
module dma_cluster_tb;
  localparam int clk_period = 40;
  localparam logic [31:0] tcdm_lo = 32'h1000_0000;
  localparam logic [31:0] tcdm_hi = 32'h1010_0000;
  localparam logic [31:0] soc_lo = 32'h0000_0000;
  // words copied over all launches below
  localparam int total_words = 16 + 12 + 1 + 0 + 9 + 6;
  localparam int watchdog_cycles = total_words * 40 + 2000;

  logic clk_i;
  logic reset_i;
  logic cfg_req_i, cfg_we_i, cfg_gnt_o, cfg_rvalid_o;
  logic [31:0] cfg_addr_i, cfg_wdata_i, cfg_rdata_o;
  logic [0:0] cfg_core_i;
  logic tcdm_req_o, tcdm_we_o, tcdm_gnt_i, tcdm_rvalid_i;
  logic [31:0] tcdm_addr_o, tcdm_wdata_o, tcdm_rdata_i;
  logic soc_req_o, soc_we_o, soc_gnt_i, soc_rvalid_i;
  logic [31:0] soc_addr_o, soc_wdata_o, soc_rdata_i;
  logic [1:0] busy_o, term_event_o, term_irq_o;

  // reference state of registers and of the running copy
  logic [31:0] shadow_src, shadow_dst, shadow_len, exp_rdata;
  logic [31:0] cur_src, cur_dst;
  logic [15:0] cur_len, rd_cnt, wr_cnt, done_cnt;
  logic cur_irq, xfer_open;
  logic [0:0] cur_core;
  int errors = 0;

  logic len_wr, acc, rd_acc, launch_acc, ev;
  logic rd_t, rd_s, wr_t, wr_s, rd_any, wr_any;
  logic [31:0] rd_addr, wr_addr, wr_data;
  logic [1:0] exp_busy;

  dma_cluster_top dma_cluster_top_inst (.*);

  dma_mem_model #(.base(tcdm_lo), .words(4096)) tcdm_mem_inst (
    .clk_i, .reset_i, .req_i(tcdm_req_o), .we_i(tcdm_we_o), .addr_i(tcdm_addr_o),
    .wdata_i(tcdm_wdata_o), .gnt_o(tcdm_gnt_i), .rvalid_o(tcdm_rvalid_i), .rdata_o(tcdm_rdata_i)
  );

  dma_mem_model #(.base(soc_lo), .words(4096)) soc_mem_inst (
    .clk_i, .reset_i, .req_i(soc_req_o), .we_i(soc_we_o), .addr_i(soc_addr_o),
    .wdata_i(soc_wdata_o), .gnt_o(soc_gnt_i), .rvalid_o(soc_rvalid_i), .rdata_o(soc_rdata_i)
  );

  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return (addr * 32'h9e37_79b1) ^ {addr[7:0], addr[31:8]};
  endfunction

  function automatic logic in_tcdm(input logic [31:0] addr);
    return addr >= tcdm_lo && addr < tcdm_hi;
  endfunction

  function automatic logic [31:0] expected_read(input logic [3:0] offset);
    case (offset)
      4'h0: return shadow_src;
      4'h4: return shadow_dst;
      4'h8: return {shadow_len[31], 15'b0, shadow_len[15:0]};
      4'hc: return {done_cnt + 16'(ev), 15'b0, xfer_open && !ev};
      default: return 32'h0;
    endcase
  endfunction

  task automatic report_error(input string msg);
    errors++;
    $display("error at time %0t: %s", $time, msg);
  endtask

  assign acc = cfg_req_i && cfg_gnt_o;
  assign rd_acc = acc && !cfg_we_i;
  assign len_wr = cfg_req_i && cfg_we_i && cfg_addr_i[3:0] == 4'h8;
  assign launch_acc = len_wr && cfg_gnt_o;
  assign ev = |term_event_o;
  assign rd_t = tcdm_req_o && tcdm_gnt_i && !tcdm_we_o;
  assign rd_s = soc_req_o && soc_gnt_i && !soc_we_o;
  assign wr_t = tcdm_req_o && tcdm_gnt_i && tcdm_we_o;
  assign wr_s = soc_req_o && soc_gnt_i && soc_we_o;
  assign rd_any = rd_t || rd_s;
  assign wr_any = wr_t || wr_s;
  assign rd_addr = rd_t ? tcdm_addr_o : soc_addr_o;
  assign wr_addr = wr_t ? tcdm_addr_o : soc_addr_o;
  assign wr_data = wr_t ? tcdm_wdata_o : soc_wdata_o;
  // busy is already low in the event cycle
  assign exp_busy = (xfer_open && !ev) ? (2'b1 << cur_core) : 2'b0;

  always @(posedge clk_i) begin
    if (reset_i) begin
      xfer_open <= 1'b0;
      done_cnt <= '0;
      rd_cnt <= '0;
      wr_cnt <= '0;
    end else begin
      if (acc && cfg_we_i) begin
        case (cfg_addr_i[3:0])
          4'h0: shadow_src <= cfg_wdata_i;
          4'h4: shadow_dst <= cfg_wdata_i;
          4'h8: shadow_len <= cfg_wdata_i;
          default: ;
        endcase
      end
      if (rd_acc) begin
        exp_rdata <= expected_read(cfg_addr_i[3:0]);
      end
      if (rd_any) begin
        rd_cnt <= rd_cnt + 16'd1;
      end
      if (wr_any) begin
        wr_cnt <= wr_cnt + 16'd1;
      end
      if (ev) begin
        xfer_open <= 1'b0;
        done_cnt <= done_cnt + 16'd1;
      end
      // a launch in the event cycle opens the next copy
      if (launch_acc) begin
        xfer_open <= 1'b1;
        cur_src <= shadow_src;
        cur_dst <= shadow_dst;
        cur_len <= cfg_wdata_i[15:0];
        cur_irq <= cfg_wdata_i[31];
        cur_core <= cfg_core_i;
        rd_cnt <= '0;
        wr_cnt <= '0;
      end
    end
  end

  readback: assert property (@(posedge clk_i) disable iff (reset_i)
    rd_acc |=> cfg_rvalid_o && cfg_rdata_o == exp_rdata)
    else report_error("register read data or rvalid wrong");
  rvalid_only_after_read: assert property (@(posedge clk_i) disable iff (reset_i)
    cfg_rvalid_o |-> $past(rd_acc))
    else report_error("cfg_rvalid_o without an accepted read");
  launch_backpressure: assert property (@(posedge clk_i) disable iff (reset_i)
    cfg_gnt_o == (cfg_req_i && !(len_wr && (|exp_busy))))
    else report_error("cfg_gnt_o wrong for this request");
  busy_window: assert property (@(posedge clk_i) disable iff (reset_i)
    busy_o == exp_busy)
    else report_error("busy_o wrong");
  tcdm_window: assert property (@(posedge clk_i) disable iff (reset_i)
    tcdm_req_o |-> in_tcdm(tcdm_addr_o))
    else report_error("tcdm request outside the tcdm window");
  soc_window: assert property (@(posedge clk_i) disable iff (reset_i)
    soc_req_o |-> !in_tcdm(soc_addr_o))
    else report_error("soc request inside the tcdm window");
  read_order: assert property (@(posedge clk_i) disable iff (reset_i)
    rd_any |-> xfer_open && rd_cnt < cur_len && rd_addr == cur_src + {rd_cnt, 2'b00})
    else report_error("read address out of sequence");
  write_data: assert property (@(posedge clk_i) disable iff (reset_i)
    wr_any |-> xfer_open && wr_cnt < cur_len && wr_addr == cur_dst + {wr_cnt, 2'b00}
      && wr_data == fill_word(cur_src + {wr_cnt, 2'b00}))
    else report_error("write address or data wrong");
  event_routing: assert property (@(posedge clk_i) disable iff (reset_i)
    ev |-> xfer_open && term_event_o == (2'b1 << cur_core) && rd_cnt == cur_len
      && wr_cnt == cur_len)
    else report_error("term_event_o wrong core or copy incomplete");
  irq_routing: assert property (@(posedge clk_i) disable iff (reset_i)
    term_irq_o == ((ev && cur_irq) ? (2'b1 << cur_core) : 2'b0))
    else report_error("term_irq_o wrong");
  event_pulse: assert property (@(posedge clk_i) disable iff (reset_i)
    ev |=> !ev)
    else report_error("term_event_o longer than one cycle");

  task automatic cfg_access(input logic [0:0] core, input logic we, input logic [31:0] addr,
                            input logic [31:0] data);
    logic granted;
    cfg_req_i = 1'b1;
    cfg_we_i = we;
    cfg_addr_i = addr;
    cfg_wdata_i = data;
    cfg_core_i = core;
    do begin
      @(negedge clk_i);
      granted = cfg_gnt_o;
      @(posedge clk_i);
      #5;
    end while (!granted);
    cfg_req_i = 1'b0;
    cfg_we_i = 1'b0;
  endtask

  task automatic launch(input logic [0:0] core, input logic [31:0] src, input logic [31:0] dst,
                        input logic [15:0] len, input logic irq);
    dma_pkg::cfg_word_u cmd;
    cmd.len_cmd.irq_en = irq;
    cmd.len_cmd.unused = '0;
    cmd.len_cmd.len = len;
    cfg_access(core, 1'b1, 32'h0, src);
    cfg_access(core, 1'b1, 32'h4, dst);
    cfg_access(core, 1'b1, 32'h8, cmd.addr);
  endtask

  task automatic wait_event();
    do begin
      @(negedge clk_i);
    end while (!(|term_event_o));
    @(posedge clk_i);
    #5;
  endtask

  initial begin
    clk_i = 1'b0;
    forever #(clk_period / 2) clk_i = ~clk_i;
  end

  initial begin
    #(watchdog_cycles * clk_period);
    $display("watchdog expired: the copies did not finish in time");
    $display("Result: FAILED");
    $finish;
  end

  initial begin
    reset_i = 1'b1;
    cfg_req_i = 1'b0;
    cfg_we_i = 1'b0;
    cfg_addr_i = '0;
    cfg_wdata_i = '0;
    cfg_core_i = '0;
    for (int i = 0; i < 4096; i++) begin
      tcdm_mem_inst.mem[i] = fill_word(tcdm_lo + 32'(i * 4));
      soc_mem_inst.mem[i] = fill_word(soc_lo + 32'(i * 4));
    end
    repeat (8) @(posedge clk_i);
    #5;
    reset_i = 1'b0;
    @(posedge clk_i);
    #5;

    // register readback from both cores
    cfg_access(1'b0, 1'b1, 32'h0, 32'h1000_0100);
    cfg_access(1'b1, 1'b1, 32'h4, 32'h0000_0200);
    cfg_access(1'b1, 1'b0, 32'h0, 32'h0);
    cfg_access(1'b0, 1'b0, 32'h4, 32'h0);
    cfg_access(1'b0, 1'b0, 32'hc, 32'h0);

    // tcdm to soc, soc to tcdm, within tcdm, then single word and empty copies
    launch(1'b0, 32'h1000_0100, 32'h0000_0200, 16'd16, 1'b1);
    wait_event();
    launch(1'b1, 32'h0000_0800, 32'h1000_0800, 16'd12, 1'b0);
    wait_event();
    launch(1'b0, 32'h1000_0400, 32'h1000_0c00, 16'd1, 1'b1);
    wait_event();
    launch(1'b1, 32'h1000_0500, 32'h1000_0d00, 16'd0, 1'b1);
    wait_event();
    cfg_access(1'b0, 1'b0, 32'h8, 32'h0);
    cfg_access(1'b1, 1'b0, 32'hc, 32'h0);

    // second launch waits for the first to end
    launch(1'b0, 32'h1000_0600, 32'h1000_0e00, 16'd9, 1'b0);
    launch(1'b1, 32'h0000_0a00, 32'h1000_0f00, 16'd6, 1'b1);
    wait_event();
    cfg_access(1'b0, 1'b0, 32'hc, 32'h0);
    repeat (4) @(posedge clk_i);

    $display("%0d transfers completed, %0d errors", done_cnt, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== tests/dma_mem_model.sv ====
// memory model: word memory behind a req/gnt/rvalid port, grants stall on lfsr bits
module dma_mem_model #(
  parameter logic [31:0] base = 32'h0,
  parameter int words = 4096
) (
  input  logic        clk_i,
  input  logic        reset_i,
  input  logic        req_i,
  input  logic        we_i,
  input  logic [31:0] addr_i,
  input  logic [31:0] wdata_i,
  output logic        gnt_o,
  output logic        rvalid_o,
  output logic [31:0] rdata_o
);
  localparam int idx_w = $clog2(words);

  logic [31:0] mem [words];
  logic [31:0] lfsr_q;
  logic [idx_w-1:0] index;

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  assign index = idx_w'((addr_i - base) >> 2);

  // one fresh lfsr bit per cycle decides the stall
  assign gnt_o = req_i && !lfsr_q[0];

  always @(posedge clk_i) begin
    if (gnt_o && we_i) begin
      mem[index] <= wdata_i;
    end
  end

  // read data one cycle after grant, in grant order
  always @(posedge clk_i) begin
    if (reset_i) begin
      lfsr_q <= 32'h5a50;
      rvalid_o <= 1'b0;
    end else begin
      lfsr_q <= lfsr_step(lfsr_q);
      rvalid_o <= gnt_o && !we_i;
      if (gnt_o && !we_i) begin
        rdata_o <= mem[index];
      end
    end
  end

endmodule
